/* superscalar_execute_stage.f */
+incdir+testbench
logic/exec_pkg.sv
logic/alu_shifter.sv
logic/branch_resolver.sv
logic/exec_lane.sv
logic/superscalar_execute_stage.sv
testbench/exec_tb.sv

/* Bender.yml */
package:
  name: superscalar_execute_stage

sources:
  # Design, in compile order
  - logic/exec_pkg.sv
  - logic/alu_shifter.sv
  - logic/branch_resolver.sv
  - logic/exec_lane.sv
  - logic/superscalar_execute_stage.sv

  # Testbench, the model header sits next to it
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/exec_tb.sv

/* testbench/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// ============================================================
// Reference model for one RV32I execute lane
// ============================================================

// ALU result from the function select
function automatic logic [31:0] alu_compute(input logic [31:0] a, input logic [31:0] b,
                                            input exec_pkg::func_sel_t fn);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh = b[4:0];
    // Ones shifted in from the left for a negative operand
    fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
    case (fn)
        exec_pkg::FN_ADD:    return a + b;
        exec_pkg::FN_SUB:    return a - b;
        exec_pkg::FN_SLL:    return a << sh;
        exec_pkg::FN_SLT:    return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
        exec_pkg::FN_SLTU:   return (a < b) ? 32'd1 : 32'd0;
        exec_pkg::FN_XOR:    return a ^ b;
        exec_pkg::FN_SRL:    return a >> sh;
        exec_pkg::FN_SRA:    return (a >> sh) | fill;
        exec_pkg::FN_OR:     return a | b;
        exec_pkg::FN_AND:    return a & b;
        exec_pkg::FN_PASS_B: return b;
        default:             return 32'h0;
    endcase
endfunction

// Branch direction, compares come through the ALU result
function automatic logic branch_taken(input exec_pkg::branch_sel_t sel, input logic [31:0] res);
    case (sel)
        exec_pkg::BR_EQ, exec_pkg::BR_GE:    return (res == 32'h0);
        exec_pkg::BR_NE, exec_pkg::BR_LT:    return (res != 32'h0);
        exec_pkg::BR_JAL, exec_pkg::BR_JALR: return 1'b1;
        default:                             return 1'b0;
    endcase
endfunction

// Codes 1 to 5 are conditional
function automatic logic trains_predictor(input exec_pkg::branch_sel_t sel);
    return (sel >= 3'd1) && (sel <= 3'd5);
endfunction

function automatic logic mispredicted(input exec_pkg::branch_sel_t sel, input logic taken,
                                      input logic ptaken, input logic [31:0] res,
                                      input logic [31:0] ppc);
    if (sel == exec_pkg::BR_JALR) return ({res[31:1], 1'b0} != ppc);
    if (sel == exec_pkg::BR_NONE) return 1'b0;
    return taken ^ ptaken;
endfunction

function automatic logic [31:0] redirect_pc(input exec_pkg::branch_sel_t sel,
                                            input logic taken, input logic [31:0] res,
                                            input logic [31:0] pc, input logic [31:0] bt);
    if (sel == exec_pkg::BR_JALR) return {res[31:1], 1'b0};
    if (taken) return bt;
    return pc + 32'd4;
endfunction

// Return address for link instructions, ALU result otherwise
function automatic logic [31:0] writeback_value(input logic link, input logic [31:0] pc,
                                                input logic [31:0] res);
    if (link) return pc + 32'd4;
    return res;
endfunction

// A load always forms an address, a store only without the data write
function automatic logic addr_calc_flag(input logic load, input logic store, input logic wb);
    if (load) return 1'b1;
    return store && !wb;
endfunction

`endif

/* testbench/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

    localparam int LANES          = 3;
    localparam int CLK_PERIOD     = 40;
    localparam int NUM_TESTS      = 6;
    localparam int ITEMS_PER_TEST = 64;
    localparam int WATCHDOG_NS    = (NUM_TESTS * ITEMS_PER_TEST + 20) * CLK_PERIOD;

    `include "exec_model.svh"

    logic clk;
    logic rst;

    // DUT inputs
    logic [LANES-1:0]                  issue_valid;
    logic [LANES-1:0][31:0]            data_a;
    logic [LANES-1:0][31:0]            data_b;
    exec_pkg::ctrl_t [LANES-1:0]       control;
    exec_pkg::branch_sel_t [LANES-1:0] branch_sel;
    exec_pkg::phys_reg_t [LANES-1:0]   rd_tag;
    logic [LANES-1:0][31:0]            pc;
    logic [LANES-1:0][31:0]            branch_target;
    logic [LANES-1:0]                  predicted_taken;
    logic [LANES-1:0][31:0]            predicted_pc;

    // DUT outputs
    logic [LANES-1:0]                  cdb_valid;
    exec_pkg::phys_reg_t [LANES-1:0]   cdb_tag;
    logic [LANES-1:0][31:0]            cdb_data;
    logic [LANES-1:0]                  mem_addr_calc;
    logic [LANES-1:0]                  update_predictor;
    logic [LANES-1:0][31:0]            predictor_pc;
    logic [LANES-1:0]                  mispredict;
    logic [LANES-1:0][31:0]            correct_pc;
    logic [LANES-1:0]                  is_jalr;

    // Stimulus seen at the last rising edge
    logic                              prev_rst;
    logic [LANES-1:0]                  prev_valid;
    logic [LANES-1:0][31:0]            prev_a;
    logic [LANES-1:0][31:0]            prev_b;
    exec_pkg::ctrl_t [LANES-1:0]       prev_ctrl;
    exec_pkg::branch_sel_t [LANES-1:0] prev_bsel;
    exec_pkg::phys_reg_t [LANES-1:0]   prev_tag;
    logic [LANES-1:0][31:0]            prev_pc;
    logic [LANES-1:0][31:0]            prev_bt;
    logic [LANES-1:0]                  prev_ptaken;
    logic [LANES-1:0][31:0]            prev_ppc;

    int error_count;
    int check_count;
    int test_errors_base;
    int tests_run;
    int tests_failed;

    superscalar_execute_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // ============================================================
    // Checking
    // ============================================================

    always @(posedge clk) begin
        prev_rst    <= rst;
        prev_valid  <= issue_valid;
        prev_a      <= data_a;
        prev_b      <= data_b;
        prev_ctrl   <= control;
        prev_bsel   <= branch_sel;
        prev_tag    <= rd_tag;
        prev_pc     <= pc;
        prev_bt     <= branch_target;
        prev_ptaken <= predicted_taken;
        prev_ppc    <= predicted_pc;
    end

    task automatic report_mismatch(input int l, input string name,
                                   input logic [31:0] got, input logic [31:0] exp);
        error_count++;
        $display("CHECK FAILED at %0t ns: lane %0d %s got %h expected %h",
                 $time, l, name, got, exp);
    endtask

    task automatic check_lane(input int l);
        logic        v;
        logic        tk;
        logic [31:0] res;
        logic [31:0] exp_data;
        logic [31:0] exp_pc;
        logic        exp_misp;
        logic        exp_upd;
        logic        exp_jalr;
        logic        exp_mem;
        v   = prev_valid[l] & ~prev_rst;
        res = alu_compute(prev_a[l], prev_b[l], prev_ctrl[l][exec_pkg::FUNC_LSB +: 4]);
        tk  = branch_taken(prev_bsel[l], res);
        exp_data = writeback_value(prev_ctrl[l][exec_pkg::CTRL_LINK], prev_pc[l], res);
        exp_pc   = redirect_pc(prev_bsel[l], tk, res, prev_pc[l], prev_bt[l]);
        exp_misp = v & mispredicted(prev_bsel[l], tk, prev_ptaken[l], res, prev_ppc[l]);
        exp_upd  = v & trains_predictor(prev_bsel[l]);
        exp_jalr = v & (prev_bsel[l] == exec_pkg::BR_JALR);
        exp_mem  = v & addr_calc_flag(prev_ctrl[l][exec_pkg::CTRL_LOAD],
                                      prev_ctrl[l][exec_pkg::CTRL_STORE],
                                      prev_ctrl[l][exec_pkg::CTRL_WB]);
        check_count++;
        // Flags hold zero in reset and after an idle cycle
        assert (cdb_valid[l] === v) else report_mismatch(l, "cdb_valid", cdb_valid[l], v);
        assert (mispredict[l] === exp_misp)
            else report_mismatch(l, "mispredict", mispredict[l], exp_misp);
        assert (update_predictor[l] === exp_upd)
            else report_mismatch(l, "update_predictor", update_predictor[l], exp_upd);
        assert (is_jalr[l] === exp_jalr)
            else report_mismatch(l, "is_jalr", is_jalr[l], exp_jalr);
        assert (mem_addr_calc[l] === exp_mem)
            else report_mismatch(l, "mem_addr_calc", mem_addr_calc[l], exp_mem);
        if (v) begin
            assert (cdb_tag[l] === prev_tag[l])
                else report_mismatch(l, "cdb_tag", cdb_tag[l], prev_tag[l]);
            assert (cdb_data[l] === exp_data)
                else report_mismatch(l, "cdb_data", cdb_data[l], exp_data);
            assert (predictor_pc[l] === prev_pc[l])
                else report_mismatch(l, "predictor_pc", predictor_pc[l], prev_pc[l]);
            assert (correct_pc[l] === exp_pc)
                else report_mismatch(l, "correct_pc", correct_pc[l], exp_pc);
        end
    endtask

    // Outputs are settled mid cycle
    always @(negedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            check_lane(l);
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    task automatic set_lane(input int l, input logic v, input logic [31:0] a,
                            input logic [31:0] b, input exec_pkg::func_sel_t fn,
                            input exec_pkg::branch_sel_t bsel, input logic [3:0] bits,
                            input logic ptaken, input logic [31:0] ppc);
        exec_pkg::ctrl_t c;
        // Low three bits are unused, filled with noise
        c = exec_pkg::ctrl_t'($urandom);
        c[exec_pkg::FUNC_LSB +: 4] = fn;
        {c[exec_pkg::CTRL_WB], c[exec_pkg::CTRL_LINK],
         c[exec_pkg::CTRL_LOAD], c[exec_pkg::CTRL_STORE]} = bits;
        issue_valid[l]     = v;
        data_a[l]          = a;
        data_b[l]          = b;
        control[l]         = c;
        branch_sel[l]      = bsel;
        rd_tag[l]          = exec_pkg::phys_reg_t'($urandom);
        pc[l]              = $urandom & 32'hFFFF_FFFC;
        branch_target[l]   = $urandom & 32'hFFFF_FFFC;
        predicted_taken[l] = ptaken;
        predicted_pc[l]    = ppc;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic start_test();
        test_errors_base = error_count;
    endtask

    // Idle cycle lets the last item get checked before the line is printed
    task automatic finish_test(input string name);
        int errs;
        issue_valid = '0;
        @(negedge clk);
        #1;
        errs = error_count - test_errors_base;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %s: %0d errors", name, errs);
        step();
    endtask

    // ============================================================
    // Tests
    // ============================================================

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tgt;
        exec_pkg::branch_sel_t sel;
        exec_pkg::func_sel_t   fn;
        void'($urandom(32'h2238_291d));
        error_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        issue_valid = '0;
        data_a = '0;
        data_b = '0;
        control = '0;
        branch_sel = '0;
        rd_tag = '0;
        pc = '0;
        branch_target = '0;
        predicted_taken = '0;
        predicted_pc = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset and idle
        start_test();
        repeat (8) step();
        finish_test("reset_idle");

        // Every function code on every lane
        start_test();
        for (int k = 0; k < 44; k++) begin
            for (int l = 0; l < LANES; l++) begin
                fn = exec_pkg::func_sel_t'((k + l) % 11);
                set_lane(l, 1'b1, $urandom, $urandom, fn, exec_pkg::BR_NONE, 4'b0000,
                         1'b0, 32'h0);
            end
            step();
        end
        finish_test("arith_logic");

        // Conditional branches, reserved code included
        start_test();
        for (int k = 0; k < 40; k++) begin
            for (int l = 0; l < LANES; l++) begin
                sel = exec_pkg::branch_sel_t'(1 + (k + l) % 5);
                a = $urandom;
                b = ($urandom % 4 == 0) ? a : $urandom;
                if (sel == exec_pkg::BR_EQ || sel == exec_pkg::BR_NE) fn = exec_pkg::FN_SUB;
                else if ($urandom % 2 == 0) fn = exec_pkg::FN_SLT;
                else fn = exec_pkg::FN_SLTU;
                set_lane(l, 1'b1, a, b, fn, sel, 4'b0000, $urandom % 2, $urandom);
            end
            step();
        end
        finish_test("cond_branch");

        // JAL and JALR with link, JALR prediction right or wrong
        start_test();
        for (int k = 0; k < 32; k++) begin
            for (int l = 0; l < LANES; l++) begin
                a = $urandom;
                b = ($urandom % 4096) - 2048;
                tgt = (a + b) & 32'hFFFF_FFFE;
                sel = ((k + l) % 2 == 0) ? exec_pkg::BR_JAL : exec_pkg::BR_JALR;
                set_lane(l, 1'b1, a, b, exec_pkg::FN_ADD, sel, 4'b0100, $urandom % 2,
                         ($urandom % 2 == 0) ? tgt : tgt + 32'd4);
            end
            step();
        end
        finish_test("jal_jalr");

        // Address calculation flag
        start_test();
        for (int k = 0; k < 32; k++) begin
            for (int l = 0; l < LANES; l++) begin
                set_lane(l, 1'b1, $urandom, $urandom, exec_pkg::FN_ADD, exec_pkg::BR_NONE,
                         {$urandom % 2 == 0, 1'b0, $urandom % 2 == 0, $urandom % 2 == 0},
                         1'b0, 32'h0);
            end
            step();
        end
        finish_test("mem_addr");

        // Back to back with random lane gating
        start_test();
        for (int k = 0; k < 64; k++) begin
            for (int l = 0; l < LANES; l++) begin
                set_lane(l, $urandom % 2, $urandom, $urandom,
                         exec_pkg::func_sel_t'($urandom % 11),
                         exec_pkg::branch_sel_t'($urandom), 4'($urandom),
                         $urandom % 2, $urandom);
            end
            step();
        end
        finish_test("lane_gating");

        $display("tests run %0d, tests failed %0d, lane checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* logic/superscalar_execute_stage.sv */
`timescale 1ns/1ps

module superscalar_execute_stage #(
    parameter int NUM_LANES  = 3,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // Issue side, one slice per reservation station
    input  logic [NUM_LANES-1:0]                  issue_valid,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  data_a,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  data_b,
    input  exec_pkg::ctrl_t [NUM_LANES-1:0]       control,
    input  exec_pkg::branch_sel_t [NUM_LANES-1:0] branch_sel,
    input  exec_pkg::phys_reg_t [NUM_LANES-1:0]   rd_tag,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  pc,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  branch_target,
    input  logic [NUM_LANES-1:0]                  predicted_taken,
    input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  predicted_pc,

    // CDB slots, one per lane
    output logic [NUM_LANES-1:0]                  cdb_valid,
    output exec_pkg::phys_reg_t [NUM_LANES-1:0]   cdb_tag,
    output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  cdb_data,
    output logic [NUM_LANES-1:0]                  mem_addr_calc,

    // Branch resolution to the front end
    output logic [NUM_LANES-1:0]                  update_predictor,
    output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  predictor_pc,
    output logic [NUM_LANES-1:0]                  mispredict,
    output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  correct_pc,
    output logic [NUM_LANES-1:0]                  is_jalr
);

    // ============================================================
    // Lanes
    // ============================================================

    // Lanes share nothing, each drives its own CDB slot
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exec_lane #(
            .DATA_WIDTH(DATA_WIDTH)
        ) u_lane (
            .clk             (clk),
            .rst             (rst),
            .issue_valid     (issue_valid[i]),
            .data_a          (data_a[i]),
            .data_b          (data_b[i]),
            .control         (control[i]),
            .branch_sel      (branch_sel[i]),
            .rd_tag          (rd_tag[i]),
            .pc              (pc[i]),
            .branch_target   (branch_target[i]),
            .predicted_taken (predicted_taken[i]),
            .predicted_pc    (predicted_pc[i]),
            .cdb_valid       (cdb_valid[i]),
            .cdb_tag         (cdb_tag[i]),
            .cdb_data        (cdb_data[i]),
            .mem_addr_calc   (mem_addr_calc[i]),
            .update_predictor(update_predictor[i]),
            .predictor_pc    (predictor_pc[i]),
            .mispredict      (mispredict[i]),
            .correct_pc      (correct_pc[i]),
            .is_jalr         (is_jalr[i])
        );
    end

endmodule

/* logic/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  logic [DATA_WIDTH-1:0] data_a,
    input  logic [DATA_WIDTH-1:0] data_b,
    input  exec_pkg::ctrl_t       control,
    input  exec_pkg::branch_sel_t branch_sel,
    input  exec_pkg::phys_reg_t   rd_tag,
    input  logic [DATA_WIDTH-1:0] pc,
    input  logic [DATA_WIDTH-1:0] branch_target,
    input  logic                  predicted_taken,
    input  logic [DATA_WIDTH-1:0] predicted_pc,
    output logic                  cdb_valid,
    output exec_pkg::phys_reg_t   cdb_tag,
    output logic [DATA_WIDTH-1:0] cdb_data,
    output logic                  mem_addr_calc,
    output logic                  update_predictor,
    output logic [DATA_WIDTH-1:0] predictor_pc,
    output logic                  mispredict,
    output logic [DATA_WIDTH-1:0] correct_pc,
    output logic                  is_jalr
);

    localparam int FUNC_W = $bits(exec_pkg::func_sel_t);

    exec_pkg::func_sel_t   func_sel;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  alu_zero;
    logic                  taken;
    logic                  jalr;
    logic                  conditional;
    logic [DATA_WIDTH-1:0] pc_plus4;
    logic [DATA_WIDTH-1:0] jalr_target;
    logic                  mispredict_d;
    logic [DATA_WIDTH-1:0] correct_pc_d;
    logic [DATA_WIDTH-1:0] cdb_data_d;
    logic                  mem_addr_d;

    // ============================================================
    // Functional unit and branch compare
    // ============================================================

    // Operation lives in the top bits of the control word
    assign func_sel = exec_pkg::func_sel_t'(control[exec_pkg::FUNC_LSB +: FUNC_W]);

    alu_shifter #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_alu (
        .data_a  (data_a),
        .data_b  (data_b),
        .func_sel(func_sel),
        .result  (alu_result),
        .zero    (alu_zero)
    );

    branch_resolver u_branch (
        .branch_sel (branch_sel),
        .zero       (alu_zero),
        .taken      (taken),
        .jalr       (jalr),
        .conditional(conditional)
    );

    // ============================================================
    // Resolve
    // ============================================================

    // Fall-through address, also the link value
    assign pc_plus4 = pc + DATA_WIDTH'(4);

    // JALR target with bit 0 forced low
    assign jalr_target = {alu_result[DATA_WIDTH-1:1], 1'b0};

    // JALR checks the address itself, others check direction only
    always_comb begin
        if (jalr) begin
            mispredict_d = (jalr_target != predicted_pc);
        end else if (branch_sel == exec_pkg::BR_NONE) begin
            mispredict_d = 1'b0;
        end else begin
            mispredict_d = taken ^ predicted_taken;
        end
    end

    // Where fetch should have gone
    always_comb begin
        if (jalr) begin
            correct_pc_d = jalr_target;
        end else if (taken) begin
            correct_pc_d = branch_target;
        end else begin
            correct_pc_d = pc_plus4;
        end
    end

    // Link instructions write the return address
    assign cdb_data_d = control[exec_pkg::CTRL_LINK] ? pc_plus4 : alu_result;

    // Loads always, stores only when the ALU forms the address
    assign mem_addr_d = control[exec_pkg::CTRL_LOAD] |
                        (control[exec_pkg::CTRL_STORE] & ~control[exec_pkg::CTRL_WB]);

    // ============================================================
    // Output register
    // ============================================================

    // Flags follow issue_valid so an idle cycle reads back as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid        <= 1'b0;
            mispredict       <= 1'b0;
            update_predictor <= 1'b0;
            is_jalr          <= 1'b0;
            mem_addr_calc    <= 1'b0;
        end else begin
            cdb_valid        <= issue_valid;
            mispredict       <= issue_valid & mispredict_d;
            update_predictor <= issue_valid & conditional;
            is_jalr          <= issue_valid & jalr;
            mem_addr_calc    <= issue_valid & mem_addr_d;
        end
    end

    // Payload only loads with a new instruction
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_tag      <= rd_tag;
            cdb_data     <= cdb_data_d;
            predictor_pc <= pc;
            correct_pc   <= correct_pc_d;
        end
    end

endmodule

/* logic/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver (
    input  exec_pkg::branch_sel_t branch_sel,
    input  logic                  zero,
    output logic                  taken,
    output logic                  jalr,
    output logic                  conditional
);

    // ============================================================
    // Taken decision
    // ============================================================

    // EQ and NE look at the zero flag of a subtract
    // LT and GE look at a set-less-than result, nonzero means less
    always_comb begin
        case (branch_sel)
            exec_pkg::BR_EQ: begin
                taken = zero;
            end
            exec_pkg::BR_NE: begin
                taken = ~zero;
            end
            exec_pkg::BR_LT: begin
                taken = ~zero;
            end
            exec_pkg::BR_GE: begin
                taken = zero;
            end
            exec_pkg::BR_RSVD: begin
                // Never taken
                taken = 1'b0;
            end
            exec_pkg::BR_JAL, exec_pkg::BR_JALR: begin
                // Jumps always redirect
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // ============================================================
    // Kind decode
    // ============================================================

    // JALR target comes from the ALU, so the lane treats it apart
    assign jalr = (branch_sel == exec_pkg::BR_JALR);

    // Codes 1 to 5 train the predictor
    assign conditional = (branch_sel != exec_pkg::BR_NONE) &&
                         (branch_sel < exec_pkg::BR_JAL);

endmodule

/* logic/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] data_a,
    input  logic [DATA_WIDTH-1:0] data_b,
    input  exec_pkg::func_sel_t   func_sel,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  zero
);

    // Shift amount width, five bits for RV32
    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic [SHAMT_W-1:0]    shamt;
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] diff;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // ============================================================
    // Shared datapath pieces
    // ============================================================

    // Only the low bits of operand B select the shift
    assign shamt = data_b[SHAMT_W-1:0];

    // Adder and subtractor
    assign sum  = data_a + data_b;
    assign diff = data_a - data_b;

    // Set-less-than compares
    assign lt_signed   = $signed(data_a) < $signed(data_b);
    assign lt_unsigned = data_a < data_b;

    // ============================================================
    // Result mux
    // ============================================================

    always_comb begin
        case (func_sel)
            exec_pkg::FN_ADD: begin
                result = sum;
            end
            exec_pkg::FN_SUB: begin
                result = diff;
            end
            exec_pkg::FN_SLL: begin
                result = data_a << shamt;
            end
            exec_pkg::FN_SLT: begin
                result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            end
            exec_pkg::FN_SLTU: begin
                result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            end
            exec_pkg::FN_XOR: begin
                result = data_a ^ data_b;
            end
            exec_pkg::FN_SRL: begin
                result = data_a >> shamt;
            end
            exec_pkg::FN_SRA: begin
                // Sign bit fills from the left
                result = $signed(data_a) >>> shamt;
            end
            exec_pkg::FN_OR: begin
                result = data_a | data_b;
            end
            exec_pkg::FN_AND: begin
                result = data_a & data_b;
            end
            exec_pkg::FN_PASS_B: begin
                result = data_b;
            end
            default: begin
                // Unused codes give zero
                result = '0;
            end
        endcase
    end

    // Zero flag drives the branch compare
    assign zero = (result == '0);

endmodule

/* logic/exec_pkg.sv */
package exec_pkg;

    // ============================================================
    // Field types
    // ============================================================

    // ALU operation code carried in the upper control bits
    typedef logic [3:0] func_sel_t;

    // Branch kind from the decoder
    typedef logic [2:0] branch_sel_t;

    // Physical register tag broadcast on the CDB
    typedef logic [5:0] phys_reg_t;

    // Control word from the reservation station
    typedef logic [10:0] ctrl_t;

    // ============================================================
    // Function select codes
    // ============================================================

    localparam func_sel_t FN_ADD    = 4'd0;
    localparam func_sel_t FN_SUB    = 4'd1;
    localparam func_sel_t FN_SLL    = 4'd2;
    localparam func_sel_t FN_SLT    = 4'd3;
    localparam func_sel_t FN_SLTU   = 4'd4;
    localparam func_sel_t FN_XOR    = 4'd5;
    localparam func_sel_t FN_SRL    = 4'd6;
    localparam func_sel_t FN_SRA    = 4'd7;
    localparam func_sel_t FN_OR     = 4'd8;
    localparam func_sel_t FN_AND    = 4'd9;
    // Operand B straight through, used by LUI
    localparam func_sel_t FN_PASS_B = 4'd10;

    // ============================================================
    // Branch select codes
    // ============================================================

    localparam branch_sel_t BR_NONE = 3'd0;
    localparam branch_sel_t BR_EQ   = 3'd1;
    localparam branch_sel_t BR_NE   = 3'd2;
    localparam branch_sel_t BR_LT   = 3'd3;
    localparam branch_sel_t BR_GE   = 3'd4;
    // Reserved, resolves as a conditional branch that is never taken
    localparam branch_sel_t BR_RSVD = 3'd5;
    localparam branch_sel_t BR_JAL  = 3'd6;
    localparam branch_sel_t BR_JALR = 3'd7;

    // ============================================================
    // Control word bit positions
    // ============================================================

    // Function select occupies bits 10 to 7
    localparam int FUNC_LSB   = 7;
    // Register write of store data, clear for a pure address calc
    localparam int CTRL_WB    = 6;
    // Link instruction, result is the return address
    localparam int CTRL_LINK  = 5;
    localparam int CTRL_LOAD  = 4;
    localparam int CTRL_STORE = 3;

endpackage
